// File: logic/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Encodings follow the decoder used by the rest of the core
    typedef enum logic [4:0] {
        OP_ADD   = 5'b00000,
        OP_AND   = 5'b00001,
        OP_OR    = 5'b00010,
        OP_SLL   = 5'b00011,
        OP_SRL   = 5'b00100,
        OP_SLT   = 5'b00101,
        OP_SLTU  = 5'b00110,
        OP_SRA   = 5'b00111,
        OP_SUB   = 5'b01000,
        OP_XOR   = 5'b01001,
        OP_BEQ   = 5'b01010,
        OP_BGE   = 5'b01011,
        OP_BNE   = 5'b01100,
        OP_BGEU  = 5'b01101,
        OP_LUI   = 5'b01110,
        OP_AUIPC = 5'b01111,
        OP_JAL   = 5'b10000,
        OP_JALR  = 5'b10001,
        OP_BLT   = 5'b11010,
        OP_BLTU  = 5'b11011,
        OP_NONE  = 5'b11111
    } op_e;

    typedef enum logic [1:0] {
        ST_EXEC      = 2'b00, // Waiting for the ALU
        ST_DONE      = 2'b01,
        ST_NOT_TAKEN = 2'b10
    } entry_state_e;

    typedef logic [2:0] tag_t; // Tag 0 means no producer

    localparam int ROB_DEPTH = 7;

    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic [31:0] pc;
        logic        has_imm;
    } instr_t;

    typedef struct packed {
        logic [31:0] value;
        tag_t        tag;
    } operand_t;

    typedef struct packed {
        op_e         op;
        tag_t        dest;
        operand_t    src1;
        operand_t    src2;
        logic [31:0] imm;
        logic [31:0] pc;
    } issue_t;

    typedef struct packed {
        logic        valid;
        tag_t        tag;
        logic [31:0] value;
    } cdb_t;

    typedef struct packed {
        logic        valid;
        tag_t        tag;
        logic [4:0]  rd;
        logic [31:0] value;
    } commit_t;

    function automatic logic is_branch(op_e op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    endfunction

    // LUI, AUIPC and JAL finish at allocation and never reach the station
    function automatic logic uses_alu(op_e op);
        return !(op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_NONE});
    endfunction

endpackage

`default_nettype wire

// File: logic/reg_status.sv
`default_nettype none

module reg_status (
    input  logic               clk,
    input  logic               rst,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rs2,
    output rob_pkg::operand_t  src1_raw,
    output rob_pkg::operand_t  src2_raw,
    input  logic               alloc,
    input  logic [4:0]         alloc_rd,
    input  rob_pkg::tag_t      alloc_tag,
    input  rob_pkg::commit_t   commit
);

    logic [31:0]   regs [1:31];
    rob_pkg::tag_t tags [1:31];

    // x0 reads as a present zero
    function automatic rob_pkg::operand_t read_port(logic [4:0] rs);
        rob_pkg::operand_t res;
        if (rs == 5'd0) begin
            res.value = '0;
            res.tag   = '0;
        end else begin
            res.value = regs[rs];
            res.tag   = tags[rs];
        end
        return res;
    endfunction

    always_comb begin
        src1_raw = read_port(rs1);
        src2_raw = read_port(rs2);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int r = 1; r < 32; r++) begin
                regs[r] <= '0;
                tags[r] <= '0;
            end
        end else begin
            if (commit.valid && commit.rd != 5'd0) begin
                regs[commit.rd] <= commit.value;
                // A younger rename of the same register keeps its tag
                if (tags[commit.rd] == commit.tag) begin
                    tags[commit.rd] <= '0;
                end
            end
            if (alloc && alloc_rd != 5'd0) begin
                tags[alloc_rd] <= alloc_tag; // Last write wins over the clear above
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
`default_nettype none

module reorder_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc,
    input  rob_pkg::instr_t    instr,
    input  rob_pkg::operand_t  src1_raw,
    input  rob_pkg::operand_t  src2_raw,
    output rob_pkg::tag_t      alloc_tag,
    output logic               full,
    output rob_pkg::issue_t    issue,
    output logic               issue_valid,
    input  rob_pkg::cdb_t      cdb,
    output rob_pkg::commit_t   commit,
    output logic               redirect_valid,
    output logic [31:0]        redirect_pc
);

    rob_pkg::op_e          ent_op    [1:rob_pkg::ROB_DEPTH];
    logic [4:0]            ent_rd    [1:rob_pkg::ROB_DEPTH];
    logic [31:0]           ent_pc    [1:rob_pkg::ROB_DEPTH];
    logic [31:0]           ent_imm   [1:rob_pkg::ROB_DEPTH];
    logic [31:0]           ent_value [1:rob_pkg::ROB_DEPTH];
    rob_pkg::entry_state_e ent_state [1:rob_pkg::ROB_DEPTH];

    rob_pkg::tag_t     head;
    rob_pkg::tag_t     tail;
    logic [2:0]        count;
    logic              do_commit;
    logic [31:0]       alloc_value;
    logic [31:0]       commit_value_d;
    logic              redirect_d;
    logic [31:0]       redirect_pc_d;
    rob_pkg::operand_t src1_fwd;
    rob_pkg::operand_t src2_fwd;
    logic              commit_valid_q;
    rob_pkg::tag_t     commit_tag_q;
    logic [4:0]        commit_rd_q;
    logic [31:0]       commit_value_q;

    function automatic rob_pkg::tag_t next_tag(rob_pkg::tag_t t);
        return (t == rob_pkg::tag_t'(rob_pkg::ROB_DEPTH)) ? rob_pkg::tag_t'(1) : t + 3'd1;
    endfunction

    // Resolves a renamed source from a finished entry or from this cycle's broadcast.
    // The link value of JALR is known at allocation, so it never waits on the ALU
    function automatic rob_pkg::operand_t forward(rob_pkg::operand_t raw);
        rob_pkg::operand_t res;
        res = raw;
        if (raw.tag != '0) begin
            if (ent_op[raw.tag] == rob_pkg::OP_JALR) begin
                res.value = ent_pc[raw.tag] + 32'd4;
                res.tag   = '0;
            end else if (ent_state[raw.tag] != rob_pkg::ST_EXEC) begin
                res.value = ent_value[raw.tag];
                res.tag   = '0;
            end else if (cdb.valid && cdb.tag == raw.tag) begin
                res.value = cdb.value;
                res.tag   = '0;
            end
        end
        return res;
    endfunction

    assign alloc_tag   = tail;
    assign full        = (count == 3'(rob_pkg::ROB_DEPTH));
    assign do_commit   = (count != '0) && (ent_state[head] != rob_pkg::ST_EXEC);
    assign issue_valid = alloc && rob_pkg::uses_alu(instr.op);

    always_comb begin
        src1_fwd   = forward(src1_raw);
        src2_fwd   = forward(src2_raw);
        issue.op   = instr.op;
        issue.dest = tail;
        issue.src1 = src1_fwd;
        issue.imm  = instr.imm;
        issue.pc   = instr.pc;
        if (instr.has_imm && !rob_pkg::is_branch(instr.op)) begin
            issue.src2.value = instr.imm;
            issue.src2.tag   = '0;
        end else begin
            issue.src2 = src2_fwd;
        end
    end

    always_comb begin
        case (instr.op)
            rob_pkg::OP_LUI:   alloc_value = instr.imm;
            rob_pkg::OP_AUIPC: alloc_value = instr.pc + instr.imm;
            rob_pkg::OP_JAL,
            rob_pkg::OP_JALR:  alloc_value = instr.pc + 32'd4;
            default:           alloc_value = '0;
        endcase
    end

    always_comb begin
        commit_value_d = ent_value[head];
        redirect_d     = 1'b0;
        redirect_pc_d  = ent_pc[head] + ent_imm[head];
        case (ent_op[head])
            rob_pkg::OP_JAL: begin
                commit_value_d = ent_pc[head] + 32'd4;
                redirect_d     = 1'b1;
            end
            rob_pkg::OP_JALR: begin
                commit_value_d = ent_pc[head] + 32'd4;
                redirect_d     = 1'b1;
                redirect_pc_d  = {ent_value[head][31:1], 1'b0}; // Target from the ALU
            end
            rob_pkg::OP_AUIPC: commit_value_d = ent_pc[head] + ent_imm[head];
            default: begin
                if (rob_pkg::is_branch(ent_op[head])) begin
                    commit_value_d = '0;
                    redirect_d     = (ent_state[head] == rob_pkg::ST_DONE);
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head           <= rob_pkg::tag_t'(1);
            tail           <= rob_pkg::tag_t'(1);
            count          <= '0;
            commit_valid_q <= 1'b0;
            redirect_valid <= 1'b0;
            for (int i = 1; i <= rob_pkg::ROB_DEPTH; i++) begin
                ent_state[i] <= rob_pkg::ST_EXEC;
            end
        end else begin
            if (alloc) begin
                ent_state[tail] <= rob_pkg::uses_alu(instr.op) ? rob_pkg::ST_EXEC
                                                               : rob_pkg::ST_DONE;
                tail <= next_tag(tail);
            end
            if (cdb.valid) begin
                if (rob_pkg::is_branch(ent_op[cdb.tag]) && cdb.value == '0) begin
                    ent_state[cdb.tag] <= rob_pkg::ST_NOT_TAKEN;
                end else begin
                    ent_state[cdb.tag] <= rob_pkg::ST_DONE;
                end
            end
            if (do_commit) begin
                head <= next_tag(head);
            end
            count          <= count + 3'(alloc) - 3'(do_commit);
            commit_valid_q <= do_commit;
            redirect_valid <= do_commit && redirect_d;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_op[tail]    <= instr.op;
            ent_rd[tail]    <= rob_pkg::is_branch(instr.op) ? 5'd0 : instr.rd;
            ent_pc[tail]    <= instr.pc;
            ent_imm[tail]   <= instr.imm;
            ent_value[tail] <= alloc_value;
        end
        if (cdb.valid && !rob_pkg::is_branch(ent_op[cdb.tag])) begin
            ent_value[cdb.tag] <= cdb.value;
        end
        commit_tag_q   <= head;
        commit_rd_q    <= ent_rd[head];
        commit_value_q <= commit_value_d;
        redirect_pc    <= redirect_pc_d;
    end

    always_comb begin
        commit.valid = commit_valid_q;
        commit.tag   = commit_tag_q;
        commit.rd    = commit_rd_q;
        commit.value = commit_value_q;
    end

endmodule

`default_nettype wire

// File: logic/alu_station.sv
`default_nettype none

module alu_station #(
    parameter int STATION_SLOTS = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  rob_pkg::issue_t  issue,
    input  logic             issue_valid,
    output logic             station_full,
    output rob_pkg::cdb_t    cdb
);

    localparam int IW = $clog2(STATION_SLOTS);

    rob_pkg::issue_t          slot     [STATION_SLOTS];
    logic [IW-1:0]            slot_age [STATION_SLOTS];
    logic [STATION_SLOTS-1:0] slot_valid;

    logic          pick_valid;
    logic [IW-1:0] pick;
    logic [IW-1:0] pick_age;
    logic          free_valid;
    logic [IW-1:0] free_idx;
    logic [IW:0]   n_valid;
    logic          cdb_valid_q;
    rob_pkg::tag_t cdb_tag_q;
    logic [31:0]   cdb_value_q;

    function automatic logic [31:0] alu_exec(rob_pkg::issue_t s);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = s.src1.value;
        b = s.src2.value;
        case (s.op)
            rob_pkg::OP_ADD:  res = a + b;
            rob_pkg::OP_SUB:  res = a - b;
            rob_pkg::OP_AND:  res = a & b;
            rob_pkg::OP_OR:   res = a | b;
            rob_pkg::OP_XOR:  res = a ^ b;
            rob_pkg::OP_SLL:  res = a << b[4:0];
            rob_pkg::OP_SRL:  res = a >> b[4:0];
            rob_pkg::OP_SRA:  res = $signed(a) >>> b[4:0];
            rob_pkg::OP_SLT:  res = {31'd0, $signed(a) < $signed(b)};
            rob_pkg::OP_SLTU: res = {31'd0, a < b};
            rob_pkg::OP_BEQ:  res = {31'd0, a == b}; // Branches return the condition
            rob_pkg::OP_BNE:  res = {31'd0, a != b};
            rob_pkg::OP_BLT:  res = {31'd0, $signed(a) < $signed(b)};
            rob_pkg::OP_BGE:  res = {31'd0, $signed(a) >= $signed(b)};
            rob_pkg::OP_BLTU: res = {31'd0, a < b};
            rob_pkg::OP_BGEU: res = {31'd0, a >= b};
            rob_pkg::OP_JALR: res = a + s.imm;
            default:          res = '0;
        endcase
        return res;
    endfunction

    function automatic rob_pkg::operand_t snoop(rob_pkg::operand_t src);
        rob_pkg::operand_t res;
        res = src;
        if (cdb.valid && src.tag != '0 && src.tag == cdb.tag) begin
            res.value = cdb.value;
            res.tag   = '0;
        end
        return res;
    endfunction

    // Oldest ready slot has the lowest age
    always_comb begin
        pick_valid = 1'b0;
        pick       = '0;
        pick_age   = '0;
        free_valid = 1'b0;
        free_idx   = '0;
        n_valid    = '0;
        for (int i = 0; i < STATION_SLOTS; i++) begin
            if (slot_valid[i] && slot[i].src1.tag == '0 && slot[i].src2.tag == '0 &&
                (!pick_valid || slot_age[i] < pick_age)) begin
                pick_valid = 1'b1;
                pick       = IW'(i);
                pick_age   = slot_age[i];
            end
            if (!slot_valid[i] && !free_valid) begin
                free_valid = 1'b1;
                free_idx   = IW'(i);
            end
            n_valid = n_valid + (IW + 1)'(slot_valid[i]);
        end
    end

    assign station_full = &slot_valid;

    always_ff @(posedge clk) begin
        if (!rst) begin
            slot_valid  <= '0;
            cdb_valid_q <= 1'b0;
        end else begin
            cdb_valid_q <= pick_valid;
            if (pick_valid) begin
                slot_valid[pick] <= 1'b0;
            end
            if (issue_valid && free_valid) begin
                slot_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        cdb_tag_q   <= slot[pick].dest;
        cdb_value_q <= alu_exec(slot[pick]);
        for (int i = 0; i < STATION_SLOTS; i++) begin
            slot[i].src1 <= snoop(slot[i].src1);
            slot[i].src2 <= snoop(slot[i].src2);
            if (slot_valid[i] && pick_valid && slot_age[i] > pick_age) begin
                slot_age[i] <= slot_age[i] - 1'b1; // Close the gap left by the leaving slot
            end
        end
        if (issue_valid && free_valid) begin
            slot[free_idx]      <= issue;
            slot[free_idx].src1 <= snoop(issue.src1);
            slot[free_idx].src2 <= snoop(issue.src2);
            slot_age[free_idx]  <= IW'(n_valid - (IW + 1)'(pick_valid));
        end
    end

    always_comb begin
        cdb.valid = cdb_valid_q;
        cdb.tag   = cdb_tag_q;
        cdb.value = cdb_value_q;
    end

endmodule

`default_nettype wire

// File: logic/rob_core.sv
`default_nettype none

module rob_core #(
    parameter int STATION_SLOTS = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_req,
    input  rob_pkg::instr_t  instr,
    output logic             instr_ack,
    output logic             full,
    output logic             commit_valid,
    output logic [4:0]       commit_rd,
    output logic [31:0]      commit_value,
    output rob_pkg::tag_t    commit_tag,
    output logic             redirect_valid,
    output logic [31:0]      redirect_pc
);

    typedef enum logic {
        HS_IDLE,
        HS_ACKED
    } hs_e;

    hs_e               hs_state;
    logic              alloc;
    logic              station_full;
    logic [4:0]        alloc_rd;
    rob_pkg::tag_t     alloc_tag;
    rob_pkg::operand_t src1_raw;
    rob_pkg::operand_t src2_raw;
    rob_pkg::issue_t   issue;
    logic              issue_valid;
    rob_pkg::cdb_t     cdb;
    rob_pkg::commit_t  commit;

    // Allocation happens in the first cycle that ack is high, while instr is still held
    always_ff @(posedge clk) begin
        if (!rst) begin
            hs_state <= HS_IDLE;
            alloc    <= 1'b0;
        end else begin
            alloc <= 1'b0;
            case (hs_state)
                HS_IDLE: begin
                    if (instr_req && !full && !station_full) begin
                        hs_state <= HS_ACKED;
                        alloc    <= 1'b1;
                    end
                end
                default: begin
                    if (!instr_req) begin
                        hs_state <= HS_IDLE;
                    end
                end
            endcase
        end
    end

    assign instr_ack = (hs_state == HS_ACKED);
    assign alloc_rd  = rob_pkg::is_branch(instr.op) ? 5'd0 : instr.rd; // Branch rd bits hold imm

    reg_status u_reg_status (
        .clk       (clk),
        .rst       (rst),
        .rs1       (instr.rs1),
        .rs2       (instr.rs2),
        .src1_raw  (src1_raw),
        .src2_raw  (src2_raw),
        .alloc     (alloc),
        .alloc_rd  (alloc_rd),
        .alloc_tag (alloc_tag),
        .commit    (commit)
    );

    reorder_buffer u_reorder_buffer (
        .clk            (clk),
        .rst            (rst),
        .alloc          (alloc),
        .instr          (instr),
        .src1_raw       (src1_raw),
        .src2_raw       (src2_raw),
        .alloc_tag      (alloc_tag),
        .full           (full),
        .issue          (issue),
        .issue_valid    (issue_valid),
        .cdb            (cdb),
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    alu_station #(
        .STATION_SLOTS (STATION_SLOTS)
    ) u_alu_station (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .issue_valid  (issue_valid),
        .station_full (station_full),
        .cdb          (cdb)
    );

    assign commit_valid = commit.valid;
    assign commit_rd    = commit.rd;
    assign commit_value = commit.value;
    assign commit_tag   = commit.tag;

endmodule

`default_nettype wire

// File: tests/rob_core_chk.sv
`default_nettype none

module rob_core_chk (
    input logic          clk,
    input logic          rst,
    input logic          instr_req,
    input logic          instr_ack,
    input logic          full,
    input logic          commit_valid,
    input rob_pkg::tag_t commit_tag,
    input logic          redirect_valid
);

    rob_pkg::tag_t last_tag;
    logic          in_reset_q;
    int            failures = 0;

    // Tags run 1 to 7 and then start over at 1
    function automatic rob_pkg::tag_t tag_after(rob_pkg::tag_t t);
        return (t == 3'd7) ? 3'd1 : t + 3'd1;
    endfunction

    always_ff @(posedge clk) begin
        in_reset_q <= !rst;
        if (!rst) begin
            last_tag <= 3'd7; // So the first commit after reset must carry tag 1
        end else if (commit_valid) begin
            last_tag <= commit_tag;
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(instr_ack) |-> instr_req && $past(instr_req))
        else begin
            $error("instr_ack rose without a pending instr_req");
            failures++;
        end

    ack_not_when_full: assert property (@(posedge clk) disable iff (!rst)
        $rose(instr_ack) |-> !$past(full))
        else begin
            $error("instr_ack rose while the reorder buffer was full");
            failures++;
        end

    tag_in_order: assert property (@(posedge clk) disable iff (!rst)
        commit_valid |-> commit_tag == tag_after(last_tag))
        else begin
            $error("commit_tag did not follow the previous commit in order");
            failures++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        (!rst && in_reset_q) |-> !commit_valid && !redirect_valid)
        else begin
            $error("commit or redirect was high during reset");
            failures++;
        end

endmodule

bind rob_core rob_core_chk u_rob_core_chk (
    .clk            (clk),
    .rst            (rst),
    .instr_req      (instr_req),
    .instr_ack      (instr_ack),
    .full           (full),
    .commit_valid   (commit_valid),
    .commit_tag     (commit_tag),
    .redirect_valid (redirect_valid)
);

`default_nettype wire

// File: tests/rob_core_tb.sv
`default_nettype none

module rob_core_tb;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
        logic        redirect;
        logic [31:0] target;
    } exp_commit_t;

    logic            clk;
    logic            rst;
    logic            instr_req;
    rob_pkg::instr_t instr;
    logic            instr_ack;
    logic            full;
    logic            commit_valid;
    logic [4:0]      commit_rd;
    logic [31:0]     commit_value;
    rob_pkg::tag_t   commit_tag;
    logic            redirect_valid;
    logic [31:0]     redirect_pc;

    exp_commit_t  pending_q [$]; // Expected commits in program order
    logic [31:0]  model_regs [32];
    logic [31:0]  lcg_state;
    logic [31:0]  pc;
    int           errors;
    int           errors_at_start;
    int           tests_passed;
    int           tests_failed;
    int           full_cycles;
    int           total_fail;
    rob_pkg::op_e alu_ops [10] = '{rob_pkg::OP_ADD, rob_pkg::OP_SUB, rob_pkg::OP_AND,
                                   rob_pkg::OP_OR, rob_pkg::OP_XOR, rob_pkg::OP_SLL,
                                   rob_pkg::OP_SRL, rob_pkg::OP_SRA, rob_pkg::OP_SLT,
                                   rob_pkg::OP_SLTU};
    rob_pkg::op_e branch_ops [6] = '{rob_pkg::OP_BEQ, rob_pkg::OP_BNE, rob_pkg::OP_BLT,
                                     rob_pkg::OP_BGE, rob_pkg::OP_BLTU, rob_pkg::OP_BGEU};

    rob_core #(
        .STATION_SLOTS (4)
    ) u_rob_core (
        .clk            (clk),
        .rst            (rst),
        .instr_req      (instr_req),
        .instr          (instr),
        .instr_ack      (instr_ack),
        .full           (full),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .commit_tag     (commit_tag),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'((next_rand() >> 16) % 9); // x0 to x8 keeps the chain dense
    endfunction

    function automatic logic cond_holds(rob_pkg::op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            rob_pkg::OP_BEQ:  return a == b;
            rob_pkg::OP_BNE:  return a != b;
            rob_pkg::OP_BLT:  return $signed(a) < $signed(b);
            rob_pkg::OP_BGE:  return $signed(a) >= $signed(b);
            rob_pkg::OP_BLTU: return a < b;
            default:          return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] alu_model(rob_pkg::op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            rob_pkg::OP_SUB:  return a - b;
            rob_pkg::OP_AND:  return a & b;
            rob_pkg::OP_OR:   return a | b;
            rob_pkg::OP_XOR:  return a ^ b;
            rob_pkg::OP_SLL:  return a << b[4:0];
            rob_pkg::OP_SRL:  return a >> b[4:0];
            rob_pkg::OP_SRA:  return $signed(a) >>> b[4:0];
            rob_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rob_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:          return a + b;
        endcase
    endfunction

    task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("ERROR %s got %h expected %h", name, got, want);
        errors++;
    endtask

    task automatic report_fault(input string what);
        $display("%s", what);
        errors++;
    endtask

    always @(posedge clk) begin : commit_monitor
        exp_commit_t exp;
        if (rst) begin
            if (full) begin
                full_cycles++;
                // The buffer can only be full with seven instructions outstanding
                assert (pending_q.size() >= rob_pkg::ROB_DEPTH)
                    else value_error("full", 32'(full), 32'd0);
            end
            if (commit_valid) begin
                if (pending_q.size() == 0) begin
                    report_fault("A commit arrived with no instruction outstanding");
                end else begin
                    exp = pending_q.pop_front();
                    assert (commit_rd == exp.rd)
                        else value_error("commit_rd", 32'(commit_rd), 32'(exp.rd));
                    assert (commit_value == exp.value)
                        else value_error("commit_value", commit_value, exp.value);
                    assert (redirect_valid == exp.redirect)
                        else value_error("redirect_valid", 32'(redirect_valid), 32'(exp.redirect));
                    if (exp.redirect) begin
                        assert (redirect_pc == exp.target)
                            else value_error("redirect_pc", redirect_pc, exp.target);
                    end
                end
            end else begin
                assert (!redirect_valid)
                    else report_fault("redirect_valid was high without a commit");
            end
        end
    end

    // Runs the four-phase handshake and starts right after a rising edge
    task automatic send(input rob_pkg::instr_t ins);
        int waited;
        instr     <= ins;
        instr_req <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!instr_ack && waited < 100);
        if (!instr_ack) begin
            report_fault("instr_ack did not rise within 100 cycles");
        end
        instr_req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (instr_ack && waited < 100);
        if (instr_ack) begin
            report_fault("instr_ack did not fall within 100 cycles");
        end
    endtask

    task automatic issue_instr(input rob_pkg::op_e op, input logic [4:0] rd,
                               input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [31:0] imm, input logic has_imm);
        rob_pkg::instr_t ins;
        exp_commit_t     exp;
        logic [31:0]     a;
        logic [31:0]     b;
        ins.op      = op;
        ins.rd      = rd;
        ins.rs1     = rs1;
        ins.rs2     = rs2;
        ins.imm     = imm;
        ins.pc      = pc;
        ins.has_imm = has_imm;
        a = model_regs[rs1];
        b = has_imm ? imm : model_regs[rs2];
        exp.rd       = rd;
        exp.redirect = 1'b0;
        exp.target   = pc + imm;
        case (op)
            rob_pkg::OP_LUI:   exp.value = imm;
            rob_pkg::OP_AUIPC: exp.value = pc + imm;
            rob_pkg::OP_JAL: begin
                exp.value    = pc + 32'd4;
                exp.redirect = 1'b1;
            end
            rob_pkg::OP_JALR: begin
                exp.value    = pc + 32'd4;
                exp.redirect = 1'b1;
                exp.target   = (a + imm) & ~32'd1;
            end
            rob_pkg::OP_BEQ, rob_pkg::OP_BNE, rob_pkg::OP_BLT,
            rob_pkg::OP_BGE, rob_pkg::OP_BLTU, rob_pkg::OP_BGEU: begin
                exp.rd       = 5'd0; // Branches retire with nothing to write
                exp.value    = '0;
                exp.redirect = cond_holds(op, a, model_regs[rs2]);
            end
            default: exp.value = alu_model(op, a, b);
        endcase
        if (exp.rd != 5'd0) begin
            model_regs[exp.rd] = exp.value;
        end
        pending_q.push_back(exp);
        pc = pc + 32'd4;
        send(ins);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending_q.size() != 0 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (pending_q.size() != 0) begin
            report_fault("Expected commits did not arrive within 200 cycles");
            pending_q.delete();
        end
        @(posedge clk);
    endtask

    task automatic end_test(input string name, input string note);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: pass%s", name, note);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors%s", name, errors - errors_at_start, note);
        end
        errors_at_start = errors;
    endtask

    initial begin : main
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        rst             = 1'b0;
        instr_req       = 1'b0;
        instr           = '0;
        lcg_state       = 32'hd9b3_bcc2;
        pc              = 32'h0000_1000;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        full_cycles     = 0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        assert (!instr_ack) else value_error("instr_ack", 32'(instr_ack), 32'd0);
        assert (!full) else value_error("full", 32'(full), 32'd0);
        assert (!commit_valid) else value_error("commit_valid", 32'(commit_valid), 32'd0);
        assert (!redirect_valid) else value_error("redirect_valid", 32'(redirect_valid), 32'd0);
        end_test("1 reset state", "");

        for (int k = 1; k <= 8; k++) begin
            issue_instr(rob_pkg::OP_LUI, 5'(k), 5'd0, 5'd0, next_rand() & 32'hffff_f000, 1'b1);
        end
        for (int k = 0; k < 24; k++) begin
            r   = next_rand();
            rd  = rand_reg();
            rs1 = rand_reg();
            rs2 = rand_reg();
            issue_instr(alu_ops[r[27:24] % 10], rd, rs1, rs2, {{20{r[11]}}, r[11:0]}, r[31]);
        end
        issue_instr(rob_pkg::OP_XOR, 5'd0, 5'd1, 5'd2, 32'd0, 1'b0);
        issue_instr(rob_pkg::OP_OR, 5'd9, 5'd0, 5'd0, 32'd0, 1'b0); // x0 still reads zero
        drain();
        end_test("2 dependent chain", "");

        issue_instr(rob_pkg::OP_ADD, 5'd1, 5'd0, 5'd0, 32'd5, 1'b1);
        issue_instr(rob_pkg::OP_ADD, 5'd2, 5'd0, 5'd0, 32'hffff_fffd, 1'b1);
        issue_instr(rob_pkg::OP_ADD, 5'd3, 5'd0, 5'd0, 32'd5, 1'b1);
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                r   = next_rand();
                rs1 = (p == 2) ? 5'd2 : 5'd1;
                rs2 = (p == 0) ? 5'd3 : ((p == 1) ? 5'd2 : 5'd1);
                issue_instr(branch_ops[k], 5'd0, rs1, rs2, {{19{r[12]}}, r[12:1], 1'b0}, 1'b0);
                drain(); // Nothing issues behind an unresolved branch
            end
        end
        end_test("3 conditional branches", "");

        issue_instr(rob_pkg::OP_JAL, 5'd5, 5'd0, 5'd0, 32'h0000_0100, 1'b1);
        drain();
        issue_instr(rob_pkg::OP_ADD, 5'd1, 5'd1, 5'd0, 32'h0000_0233, 1'b1);
        issue_instr(rob_pkg::OP_JALR, 5'd6, 5'd1, 5'd0, 32'h0000_0011, 1'b1); // Odd target
        drain();
        issue_instr(rob_pkg::OP_AUIPC, 5'd7, 5'd0, 5'd0, 32'h0001_2000, 1'b1);
        issue_instr(rob_pkg::OP_ADD, 5'd8, 5'd5, 5'd6, 32'd0, 1'b0);
        issue_instr(rob_pkg::OP_JALR, 5'd0, 5'd7, 5'd0, 32'hffff_fff1, 1'b1);
        drain();
        end_test("4 jumps and auipc", "");

        full_cycles = 0;
        issue_instr(rob_pkg::OP_LUI, 5'd1, 5'd0, 5'd0, 32'h8000_0000, 1'b1);
        for (int k = 0; k < 8; k++) begin
            issue_instr(k[0] ? rob_pkg::OP_SRA : rob_pkg::OP_ADD, 5'd1, 5'd1, 5'd1, 32'd0, 1'b0);
        end
        drain();
        end_test("5 back-pressure", $sformatf(", full seen in %0d cycles", full_cycles));

        repeat (8) @(posedge clk); // Catch any stray commit
        total_fail = errors + u_rob_core.u_rob_core_chk.failures;
        $display("tests passed %0d, tests failed %0d, assertion failures %0d",
                 tests_passed, tests_failed, u_rob_core.u_rob_core_chk.failures);
        if (total_fail == 0 && tests_failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/rob_pkg.sv
logic/reg_status.sv
logic/reorder_buffer.sv
logic/alu_station.sv
logic/rob_core.sv
tests/rob_core_chk.sv
tests/rob_core_tb.sv

// File: Bender.yml
package:
  name: rob_core

sources:
  - logic/rob_pkg.sv
  - logic/reg_status.sv
  - logic/reorder_buffer.sv
  - logic/alu_station.sv
  - logic/rob_core.sv
  - target: test
    files:
      - tests/rob_core_chk.sv
      - tests/rob_core_tb.sv
